// ==== all.f ====
+incdir+common
common/flstory_pkg.sv
common/main_bus_if.sv
main/main_arbiter.sv
main/main_decoder.sv
main/main_ctrl_regs.sv
src/cab_inputs.sv
src/flstory_main.sv
tests/clk_gen.sv
tests/flstory_main_props.sv
tests/flstory_main_tb.sv

// ==== tests/flstory_main_tb.sv ====
// Testbench of the main CPU bus block
// Table of APB, MCU and board setting steps with expected values
// ROM model with random latency, fixed memory and cabinet inputs

`timescale 1ns/10ps

module flstory_main_tb;

    localparam int WAIT_LIMIT = 20;
    localparam int K_WR = 0, K_RD = 1, K_MCU = 2, K_CFG = 3, K_IDLE = 4;
    localparam int C_NONE = 0, C_PRDATA = 1, C_ROMA = 2, C_VRAM = 3, C_PAL = 4;
    localparam int C_ORAM = 5, C_SHA = 6, C_STRB = 7, C_VID = 8, C_SUB = 9;

    logic clk, rst;
    logic psel, penable, pwrite, pready;
    logic [15:0] paddr, mcu_addr, bus_addr, vram16_dout, pal16_dout;
    logic [7:0]  pwdata, prdata, mcu_dout, bus_dout, oram_dout, mcu_data, snd_data;
    logic mcu_busrq_n, mcu_busak_n, mcu_we, mcu_bus_rd, rom_cs, rom_ok;
    logic [16:0] rom_addr;
    logic dec_en, mirror, osdflip, oram_we, sha_we, mcu_wr, mcu_rd, snd_wr, snd_rd;
    logic [1:0]  vram_we, pal_we, coin, cab_1p, pal_bank, scr_bank;
    logic [9:0]  pal_addr, joystick1, joystick2;
    logic mcu_ibf, mcu_obf, snd_ibf, snd_obf, service, tilt;
    logic [23:0] dipsw;
    logic scr_flen, vflip, hflip, sub_rstn, sub_busrq_n;
    wire  [7:0]  rom_data;
    wire  [7:0]  sha_dout;
    logic [1:0]  rom_wait;
    integer      seed = 32'h8e88dd93;

    // Stimulus table
    int          tk[$];
    int          tc[$];
    logic [15:0] ta[$];
    logic [7:0]  td[$];
    logic [31:0] te[$];
    string       tn[$];

    string       cur_name;
    bit          entry_ok;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;
    logic [7:0]  cap_prdata;
    logic [3:0]  cap_roma;   // {rom_cs, rom_addr[16:14]}
    logic [1:0]  cap_vram;
    logic [11:0] cap_pal;
    logic [8:0]  cap_oram, cap_sha;
    logic [3:0]  cap_strb;   // {mcu_wr, mcu_rd, snd_wr, snd_rd}

    clk_gen u_clk (.clk(clk), .rst(rst));

    flstory_main dut (.*);

    assign rom_data = rom_addr[7:0] ^ 8'ha5;
    assign sha_dout = bus_addr[7:0] ^ 8'h66;

    // ROM answers after 0 to 3 extra cycles
    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok   <= 1'b0;
            rom_wait <= 2'($random(seed));
        end else if (rom_wait == 2'd0) begin
            rom_ok <= 1'b1;
        end else begin
            rom_wait <= rom_wait - 2'd1;
        end
    end

    task automatic add_entry(input int k, input int c, input logic [15:0] a,
                             input logic [7:0] d, input logic [31:0] e, input string n);
        tk.push_back(k);
        tc.push_back(c);
        ta.push_back(a);
        td.push_back(d);
        te.push_back(e);
        tn.push_back(n);
    endtask

    task automatic capture_outputs();
        cap_prdata = prdata;
        cap_roma   = {rom_cs, rom_addr[16:14]};
        cap_vram   = vram_we;
        cap_pal    = {pal_we, pal_addr};
        cap_oram   = {oram_we, bus_dout};
        cap_sha    = {sha_we, bus_dout};
        cap_strb   = {mcu_wr, mcu_rd, snd_wr, snd_rd};   // Mailbox strobes
    endtask

    task automatic wait_pready();
        bit done;
        done = 0;
        for (int n = 0; n < WAIT_LIMIT && !done; n++) begin
            @(negedge clk);
            if (pready) begin
                capture_outputs();
                done = 1;
            end
        end
        if (!done) begin
            $display("%s: host transfer did not complete within %0d cycles",
                     cur_name, WAIT_LIMIT);
            errors++;
            entry_ok = 0;
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic start_apb(input logic wr, input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= a;
        pwdata  <= d;
        @(posedge clk);
        penable <= 1'b1;
    endtask

    // MCU takes the bus, writes once, host read waits behind it
    task automatic mcu_takeover(input logic [15:0] a, input logic [7:0] d);
        bit done;
        done = 0;
        @(posedge clk);
        mcu_busrq_n <= 1'b0;
        mcu_addr    <= a;
        mcu_dout    <= d;
        for (int n = 0; n < WAIT_LIMIT && !done; n++) begin
            @(negedge clk);
            done = !mcu_busak_n;
        end
        if (!done) begin
            $display("%s: MCU bus request was not acknowledged", cur_name);
            errors++;
            entry_ok = 0;
        end
        start_apb(1'b0, a + 16'h0010, 8'h00);
        repeat (3) begin
            @(negedge clk);
            if (pready || mcu_busak_n) begin
                $display("%s: host read went ahead while the MCU held the bus", cur_name);
                errors++;
                entry_ok = 0;
            end
        end
        @(posedge clk);
        mcu_we <= 1'b1;
        @(negedge clk);
        if ({sha_we, bus_addr, bus_dout} !== {1'b1, a, d}) begin
            $display("FAILED %s: {sha_we, bus_addr, bus_dout} = %h, expected %h",
                     cur_name, {sha_we, bus_addr, bus_dout}, {1'b1, a, d});
            errors++;
            entry_ok = 0;
        end
        @(posedge clk);
        mcu_we      <= 1'b0;
        mcu_busrq_n <= 1'b1;
        wait_pready();
    endtask

    initial begin
        string       sig;
        logic [31:0] got;
        bit          rst_done;

        psel        = 0;
        penable     = 0;
        pwrite      = 0;
        paddr       = 16'h0000;
        pwdata      = 8'h00;
        mcu_busrq_n = 1;
        mcu_addr    = 16'h0000;
        mcu_dout    = 8'h00;
        mcu_we      = 0;
        mcu_bus_rd  = 0;
        rom_ok      = 0;
        rom_wait    = 0;
        dec_en      = 0;
        mirror      = 0;
        osdflip     = 0;
        vram16_dout = 16'hbeef;
        pal16_dout  = 16'h1234;
        oram_dout   = 8'h42;
        mcu_data    = 8'h5a;
        snd_data    = 8'hc3;
        mcu_ibf     = 1;
        mcu_obf     = 0;
        snd_ibf     = 0;
        snd_obf     = 1;
        coin        = 2'b10;
        cab_1p      = 2'b01;
        service     = 1;
        tilt        = 0;
        joystick1   = 10'h2b4;
        joystick2   = 10'h1c9;
        dipsw       = 24'h3ca517;

        add_entry(K_IDLE, C_SUB,    16'h0000, 8'h00, 32'h0,    "sub after reset");
        add_entry(K_WR,   C_SUB,    16'hd002, 8'h0a, 32'h2,    "sub reset off, bank 2");
        add_entry(K_WR,   C_SUB,    16'hd001, 8'h00, 32'h3,    "sub run");
        add_entry(K_WR,   C_SUB,    16'hd001, 8'h01, 32'h2,    "sub halt");
        add_entry(K_RD,   C_ROMA,   16'h8456, 8'h00, 32'he,    "banked rom addr");
        add_entry(K_RD,   C_PRDATA, 16'h8456, 8'h00, 32'hf3,   "banked rom data");
        add_entry(K_RD,   C_ROMA,   16'h1234, 8'h00, 32'h8,    "low rom addr");
        add_entry(K_RD,   C_PRDATA, 16'h1234, 8'h00, 32'h91,   "low rom data");
        add_entry(K_CFG,  C_NONE,   16'h0000, 8'h01, 32'h0,    "decrypt on");
        add_entry(K_RD,   C_PRDATA, 16'h1234, 8'h00, 32'h89,   "low rom reversed");
        add_entry(K_RD,   C_PRDATA, 16'h8456, 8'h00, 32'hcf,   "banked rom reversed");
        add_entry(K_CFG,  C_NONE,   16'h0000, 8'h02, 32'h0,    "mirror on");
        add_entry(K_WR,   C_VID,    16'hdf03, 8'h4e, 32'h4d,   "video cfg mirror");
        add_entry(K_WR,   C_PAL,    16'hdd10, 8'h11, 32'h610,  "palette low");
        add_entry(K_WR,   C_PAL,    16'hde10, 8'h22, 32'ha10,  "palette high");
        add_entry(K_CFG,  C_NONE,   16'h0000, 8'h04, 32'h0,    "osd flip on");
        add_entry(K_WR,   C_VID,    16'hdf03, 8'h63, 32'h60,   "video cfg osdflip");
        add_entry(K_WR,   C_VRAM,   16'hc000, 8'h33, 32'h1,    "vram low lane");
        add_entry(K_WR,   C_VRAM,   16'hc001, 8'h44, 32'h2,    "vram high lane");
        add_entry(K_WR,   C_ORAM,   16'hdc05, 8'h77, 32'h177,  "object ram");
        add_entry(K_WR,   C_SHA,    16'he123, 8'h88, 32'h188,  "shared ram");
        add_entry(K_RD,   C_PRDATA, 16'hd000, 8'h00, 32'h5a,   "mcu latch data");
        add_entry(K_RD,   C_STRB,   16'hd000, 8'h00, 32'h4,    "mcu latch read strobe");
        add_entry(K_WR,   C_STRB,   16'hd000, 8'h5a, 32'h8,    "mcu latch write strobe");
        add_entry(K_RD,   C_PRDATA, 16'hd400, 8'h00, 32'hc3,   "sound latch");
        add_entry(K_RD,   C_STRB,   16'hd400, 8'h00, 32'h1,    "sound latch read strobe");
        add_entry(K_WR,   C_STRB,   16'hd400, 8'h3c, 32'h2,    "sound latch write strobe");
        add_entry(K_RD,   C_PRDATA, 16'hd800, 8'h00, 32'h17,   "dip byte 0");
        add_entry(K_RD,   C_PRDATA, 16'hd801, 8'h00, 32'ha5,   "dip byte 1");
        add_entry(K_RD,   C_PRDATA, 16'hd802, 8'h00, 32'h3c,   "dip byte 2");
        add_entry(K_RD,   C_PRDATA, 16'hd803, 8'h00, 32'h9b,   "coin and start");
        add_entry(K_RD,   C_PRDATA, 16'hd804, 8'h00, 32'hb4,   "joystick 1");
        add_entry(K_RD,   C_PRDATA, 16'hd805, 8'h00, 32'hc9,   "joystick 2");
        add_entry(K_RD,   C_PRDATA, 16'hd806, 8'h00, 32'hf9,   "latch status");
        add_entry(K_MCU,  C_PRDATA, 16'he010, 8'h99, 32'h46,   "mcu bus ownership");

        rst_done = 0;
        for (int n = 0; n < WAIT_LIMIT && !rst_done; n++) begin
            @(negedge clk);
            rst_done = !rst;
        end
        if (!rst_done) begin
            $display("reset never went low");
            errors++;
        end

        for (int i = 0; i < tk.size(); i++) begin
            cur_name = tn[i];
            entry_ok = 1;
            got      = 32'h0;
            sig      = "";
            case (tk[i])
                K_WR, K_RD: begin
                    start_apb(tk[i] == K_WR, ta[i], td[i]);
                    wait_pready();
                end
                K_MCU: mcu_takeover(ta[i], td[i]);
                K_CFG: begin
                    @(posedge clk);
                    dec_en  <= td[i][0];
                    mirror  <= td[i][1];
                    osdflip <= td[i][2];
                end
                default: @(negedge clk);
            endcase
            if (tc[i] == C_VID || tc[i] == C_SUB) begin   // Flip stage is one cycle late
                @(posedge clk);
                @(negedge clk);
            end
            case (tc[i])
                C_PRDATA: begin
                    sig = "prdata";
                    got = cap_prdata;
                end
                C_ROMA: begin
                    sig = "{rom_cs, rom_addr[16:14]}";
                    got = cap_roma;
                end
                C_VRAM: begin
                    sig = "vram_we";
                    got = cap_vram;
                end
                C_PAL: begin
                    sig = "{pal_we, pal_addr}";
                    got = cap_pal;
                end
                C_ORAM: begin
                    sig = "{oram_we, bus_dout}";
                    got = cap_oram;
                end
                C_SHA: begin
                    sig = "{sha_we, bus_dout}";
                    got = cap_sha;
                end
                C_STRB: begin
                    sig = "{mcu_wr, mcu_rd, snd_wr, snd_rd}";
                    got = cap_strb;
                end
                C_VID: begin
                    sig = "{pal_bank, scr_bank, scr_flen, vflip, hflip}";
                    got = {pal_bank, scr_bank, scr_flen, vflip, hflip};
                end
                C_SUB: begin
                    sig = "{sub_rstn, sub_busrq_n}";
                    got = {sub_rstn, sub_busrq_n};
                end
                default:  sig = "";
            endcase
            if (tc[i] != C_NONE && got !== te[i]) begin
                $display("FAILED %s: %s = %h, expected %h", cur_name, sig, got, te[i]);
                errors++;
                entry_ok = 0;
            end
            if (entry_ok) begin
                passed++;
            end else begin
                failed++;
            end
            $display("%0d %s: %s", i, cur_name, entry_ok ? "ok" : "failed");
        end

        if (dut.u_arbiter.u_props.fails != 0) begin
            $display("%0d bus property violations", dut.u_arbiter.u_props.fails);
            errors += dut.u_arbiter.u_props.fails;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tk.size(), passed, failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/flstory_main_props.sv ====
// Bus and APB port properties of the main arbiter
// Bound into every main_arbiter instance

`timescale 1ns/10ps

module flstory_main_props (
    input logic        clk,
    input logic        rst,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [15:0] paddr,
    input logic [7:0]  pwdata,
    input logic        pready,
    input logic        mcu_busrq_n,
    input logic        mcu_busak_n,
    input logic        bus_we,
    input logic        bus_rd
);

    int unsigned fails = 0;   // Count of assertion failures

    // One strobe per bus cycle
    a_we_rd: assert property (@(posedge clk) disable iff (rst) !(bus_we && bus_rd))
        else begin
            fails++;
            $error("bus we and rd are high together");
        end

    // Grant held while requested, host kept waiting meanwhile
    a_grant: assert property (@(posedge clk) disable iff (rst)
        (!mcu_busrq_n && !mcu_busak_n) |=> (!mcu_busak_n && !pready))
        else begin
            fails++;
            $error("MCU bus grant dropped or host completed while the MCU held the bus");
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        (psel && !pready) |=> (psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else begin
            fails++;
            $error("host changed the transfer before pready");
        end

endmodule

bind main_arbiter flstory_main_props u_props (
    .clk         (clk),
    .rst         (rst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .pready      (pready),
    .mcu_busrq_n (mcu_busrq_n),
    .mcu_busak_n (mcu_busak_n),
    .bus_we      (bus.we),
    .bus_rd      (bus.rd)
);

// ==== tests/clk_gen.sv ====
// Testbench clock and reset source
// 100 ns clock, reset held high for the first 4 cycles

`timescale 1ns/10ps

module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== src/flstory_main.sv ====
// Main CPU bus block top level
// Host APB port, MCU bus sharing, memory map strobes and read path
// Holds the arbiter, decoder, control registers and cabinet inputs

`timescale 1ns/10ps
`include "flstory_cfg.svh"

module flstory_main import flstory_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // Host APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`FL_AW-1:0]     paddr,
    input  logic [7:0]            pwdata,
    output logic [7:0]            prdata,
    output logic                  pready,
    // MCU as bus master
    input  logic                  mcu_busrq_n,
    output logic                  mcu_busak_n,
    input  logic [`FL_AW-1:0]     mcu_addr,
    input  logic [7:0]            mcu_dout,
    input  logic                  mcu_we,
    input  logic                  mcu_bus_rd,   // MCU read strobe on the shared bus
    // ROM
    output logic                  rom_cs,
    output logic [`FL_ROM_AW-1:0] rom_addr,
    input  logic [7:0]            rom_data,
    input  logic                  rom_ok,
    input  logic                  dec_en,
    // Board configuration
    input  logic                  mirror,
    input  logic                  osdflip,
    // Shared bus to the memories
    output logic [`FL_AW-1:0]     bus_addr,
    output logic [7:0]            bus_dout,
    output logic [1:0]            vram_we,
    input  logic [15:0]           vram16_dout,
    output logic                  oram_we,
    input  logic [7:0]            oram_dout,
    output logic [1:0]            pal_we,
    output logic [`FL_PAL_AW-1:0] pal_addr,
    input  logic [15:0]           pal16_dout,
    output logic                  sha_we,
    input  logic [7:0]            sha_dout,
    // Mailboxes
    output logic                  mcu_wr,
    output logic                  mcu_rd,
    input  logic [7:0]            mcu_data,
    output logic                  snd_wr,
    output logic                  snd_rd,
    input  logic [7:0]            snd_data,
    input  logic                  mcu_ibf,
    input  logic                  mcu_obf,
    input  logic                  snd_ibf,
    input  logic                  snd_obf,
    // Cabinet
    input  logic [1:0]            coin,
    input  logic [1:0]            cab_1p,
    input  logic                  service,
    input  logic                  tilt,
    input  logic [9:0]            joystick1,
    input  logic [9:0]            joystick2,
    input  logic [23:0]           dipsw,
    // Video and sub CPU control
    output logic [1:0]            pal_bank,
    output logic [1:0]            scr_bank,
    output logic                  scr_flen,
    output logic                  vflip,
    output logic                  hflip,
    output logic                  sub_rstn,
    output logic                  sub_busrq_n
);

    main_bus_if bus ();

    logic [1:0] bank;
    logic [7:0] cab_byte;
    vid_cfg_t   vid;

    assign bus_addr = bus.addr;
    assign bus_dout = bus.dout;
    assign pal_bank = vid.pal_bank;
    assign scr_bank = vid.scr_bank;
    assign scr_flen = vid.scr_flen;
    assign vflip    = vid.vflip;
    assign hflip    = vid.hflip;

    main_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .pready      (pready),
        .prdata      (prdata),
        .mcu_busrq_n (mcu_busrq_n),
        .mcu_busak_n (mcu_busak_n),
        .mcu_addr    (mcu_addr),
        .mcu_dout    (mcu_dout),
        .mcu_we      (mcu_we),
        .mcu_rd      (mcu_bus_rd),
        .rom_ok      (rom_ok),
        .rom_cs      (rom_cs),
        .bus         (bus.master)
    );

    main_decoder u_decoder (
        .bank        (bank),
        .pal_bank    (vid.pal_bank),
        .dec_en      (dec_en),
        .rom_data    (rom_data),
        .vram16_dout (vram16_dout),
        .pal16_dout  (pal16_dout),
        .oram_dout   (oram_dout),
        .sha_dout    (sha_dout),
        .mcu_data    (mcu_data),
        .snd_data    (snd_data),
        .cab_byte    (cab_byte),
        .rom_addr    (rom_addr),
        .vram_we     (vram_we),
        .oram_we     (oram_we),
        .pal_we      (pal_we),
        .pal_addr    (pal_addr),
        .sha_we      (sha_we),
        .mcu_wr      (mcu_wr),
        .mcu_rd      (mcu_rd),
        .snd_wr      (snd_wr),
        .snd_rd      (snd_rd),
        .bus         (bus.decoder)
    );

    main_ctrl_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .mirror      (mirror),
        .osdflip     (osdflip),
        .bank        (bank),
        .sub_rstn    (sub_rstn),
        .sub_busrq_n (sub_busrq_n),
        .vid         (vid),
        .bus         (bus.snoop)
    );

    cab_inputs u_cab (
        .sel         (bus.addr[2:0]),
        .dipsw       (dipsw),
        .coin        (coin),
        .cab_1p      (cab_1p),
        .service     (service),
        .tilt        (tilt),
        .joystick1   (joystick1),
        .joystick2   (joystick2),
        .mcu_ibf     (mcu_ibf),
        .mcu_obf     (mcu_obf),
        .snd_ibf     (snd_ibf),
        .snd_obf     (snd_obf),
        .cab_byte    (cab_byte)
    );

endmodule

// ==== src/cab_inputs.sv ====
// Cabinet input byte selection
// DIP switch bytes, coin and start buttons, joysticks, mailbox status flags

`timescale 1ns/10ps

module cab_inputs (
    input  logic [2:0]  sel,        // Low address bits
    input  logic [23:0] dipsw,
    input  logic [1:0]  coin,
    input  logic [1:0]  cab_1p,
    input  logic        service,
    input  logic        tilt,
    input  logic [9:0]  joystick1,
    input  logic [9:0]  joystick2,
    // Mailbox flags
    input  logic        mcu_ibf,
    input  logic        mcu_obf,
    input  logic        snd_ibf,
    input  logic        snd_obf,
    output logic [7:0]  cab_byte
);

    always_comb begin
        case (sel)
            3'd0: cab_byte = dipsw[7:0];
            3'd1: cab_byte = dipsw[15:8];
            3'd2: cab_byte = dipsw[23:16];
            3'd3: cab_byte = {coin, cab_1p, service, tilt, 2'b11};
            3'd4: cab_byte = joystick1[7:0];
            3'd5: cab_byte = joystick2[7:0];
            // Status polled by the main CPU before using the latches
            3'd6: cab_byte = {4'hf, mcu_ibf, mcu_obf, snd_ibf, snd_obf};
            default: cab_byte = 8'hff;
        endcase
    end

endmodule

// ==== main/main_ctrl_regs.sv ====
// Main CPU control registers
// ROM bank, sub CPU reset and halt, video configuration
// Flip bits pass through one more register stage with the OSD flip

`timescale 1ns/10ps
`include "flstory_cfg.svh"

module main_ctrl_regs import flstory_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       mirror,
    input  logic       osdflip,
    output logic [1:0] bank,
    output logic       sub_rstn,
    output logic       sub_busrq_n,
    output vid_cfg_t   vid,
    main_bus_if.snoop  bus
);

    logic [1:0] pal_bank;
    logic [1:0] scr_bank;
    logic       scr_flen;
    logic [1:0] pre_flip;   // {v, h} after mirror correction
    logic [1:0] flip;

    always_ff @(posedge clk) begin
        if (rst) begin
            bank        <= `FL_BANK_RST;
            sub_rstn    <= `FL_SUB_RSTN_RST;
            sub_busrq_n <= `FL_SUB_BUSRQ_RST;
        end else if (bus.we) begin
            if (bus.region == sub_ctl) begin
                sub_busrq_n <= ~bus.dout[0];   // Bit 0 set halts the sub CPU
            end
            if (bus.region == ctl) begin
                sub_rstn <= bus.dout[1];
                bank     <= bus.dout[3:2];
            end
        end
    end

    // Video configuration at DF03
    always_ff @(posedge clk) begin
        if (bus.we && bus.region == vcfg) begin
            pal_bank <= bus.dout[6:5];
            scr_bank <= bus.dout[4:3];
            scr_flen <= bus.dout[2];
            pre_flip <= bus.dout[1:0] ^ {2{mirror}};
        end
        flip <= pre_flip ^ {2{osdflip}};
    end

    assign vid.pal_bank = pal_bank;
    assign vid.scr_bank = scr_bank;
    assign vid.scr_flen = scr_flen;
    assign vid.vflip    = flip[1];
    assign vid.hflip    = flip[0];

endmodule

// ==== main/main_decoder.sv ====
// Main bus address decoder
// Region decode of the memory map and the write/read strobes
// Banked ROM address for the configured bank layout
// Read data multiplexer with optional ROM bit reversal

`timescale 1ns/10ps
`include "flstory_cfg.svh"

module main_decoder import flstory_pkg::*; (
    input  logic [1:0]              bank,
    input  logic [1:0]              pal_bank,
    input  logic                    dec_en,
    // Read sources
    input  logic [7:0]              rom_data,
    input  logic [15:0]             vram16_dout,
    input  logic [15:0]             pal16_dout,
    input  logic [7:0]              oram_dout,
    input  logic [7:0]              sha_dout,
    input  logic [7:0]              mcu_data,
    input  logic [7:0]              snd_data,
    input  logic [7:0]              cab_byte,
    // Memory side
    output logic [`FL_ROM_AW-1:0]   rom_addr,
    output logic [1:0]              vram_we,
    output logic                    oram_we,
    output logic [1:0]              pal_we,
    output logic [`FL_PAL_AW-1:0]   pal_addr,
    output logic                    sha_we,
    // Mailbox strobes
    output logic                    mcu_wr,
    output logic                    mcu_rd,
    output logic                    snd_wr,
    output logic                    snd_rd,
    main_bus_if.decoder             bus
);

    localparam bank_mode_t BANK_MODE = `FL_BANK_MODE;

    region_t    region;
    logic [7:0] vram_byte;
    logic [7:0] rom_dec;

    function automatic logic [7:0] bit_rev(input logic [7:0] a);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i] = a[7-i];
        end
        return r;
    endfunction

    // Memory map, partial decode as on the board
    always_comb begin
        region = none;
        case (bus.addr[15:14])
            2'd0, 2'd1: region = rom;
            2'd2:       region = rom_bank;
            default: begin
                case (bus.addr[13:12])
                    2'd0: region = vram;                // C000
                    2'd1: begin
                        case (bus.addr[11:10])
                            2'd0: begin                  // D000 latches
                                case (bus.addr[1:0])
                                    2'd0:    region = mcu_latch;
                                    2'd1:    region = sub_ctl;
                                    2'd2:    region = ctl;
                                    default: region = none;
                                endcase
                            end
                            2'd1: region = snd;          // D400
                            2'd2: region = cab;          // D800
                            default: begin
                                case (bus.addr[9:8])
                                    2'd0: region = oram;   // DC00
                                    2'd1: region = pal_lo;
                                    2'd2: region = pal_hi;
                                    default: region = (bus.addr[1:0] == 2'd3) ? vcfg : none;
                                endcase
                            end
                        endcase
                    end
                    default: region = sha;               // E000 to FFFF
                endcase
            end
        endcase
    end

    assign bus.region = region;

    // Write and mailbox strobes
    assign vram_we  = {2{region == vram && bus.we}} & {bus.addr[0], ~bus.addr[0]};
    assign oram_we  = (region == oram) & bus.we;
    assign sha_we   = (region == sha) & bus.we;
    assign pal_we   = {(region == pal_hi) & bus.we, (region == pal_lo) & bus.we};
    assign pal_addr = {pal_bank, bus.addr[7:0]};
    assign mcu_wr   = (region == mcu_latch) & bus.we;
    assign mcu_rd   = (region == mcu_latch) & bus.rd;
    assign snd_wr   = (region == snd) & bus.we;
    assign snd_rd   = (region == snd) & bus.rd;

    // Banked ROM address
    always_comb begin
        rom_addr = {1'b0, bus.addr};
        if (region == rom_bank && BANK_MODE != no_banks) begin
            rom_addr[16] = 1'b1;
            if (BANK_MODE == two_banks) begin
                rom_addr[15:14] = {1'b0, bank[1]};
            end else begin
                rom_addr[15:14] = bank;
            end
        end
    end

    assign vram_byte = bus.addr[0] ? vram16_dout[15:8] : vram16_dout[7:0];
    assign rom_dec   = dec_en ? bit_rev(rom_data) : rom_data;   // Decryption

    always_comb begin
        case (region)
            rom, rom_bank: bus.din = rom_dec;
            vram:          bus.din = vram_byte;
            mcu_latch:     bus.din = mcu_data;
            snd:           bus.din = snd_data;
            cab:           bus.din = cab_byte;
            oram:          bus.din = oram_dout;
            pal_lo:        bus.din = pal16_dout[7:0];
            pal_hi:        bus.din = pal16_dout[15:8];
            sha:           bus.din = sha_dout;
            default:       bus.din = 8'd0;
        endcase
    end

endmodule

// ==== main/main_arbiter.sv ====
// Main bus arbiter
// Converts host APB transfers into single-cycle bus strobes
// Grants the bus to the MCU via the busrq/busak pair
// Stretches pready for ROM fetches and while the MCU owns the bus

`timescale 1ns/10ps
`include "flstory_cfg.svh"

module main_arbiter import flstory_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // Host APB port
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [`FL_AW-1:0] paddr,
    input  logic [7:0]        pwdata,
    output logic              pready,
    output logic [7:0]        prdata,
    // MCU bus master
    input  logic              mcu_busrq_n,
    output logic              mcu_busak_n,
    input  logic [`FL_AW-1:0] mcu_addr,
    input  logic [7:0]        mcu_dout,
    input  logic              mcu_we,
    input  logic              mcu_rd,
    // ROM handshake
    input  logic              rom_ok,
    output logic              rom_cs,
    main_bus_if.master        bus
);

    logic granted;      // MCU owns the bus
    logic host_acc;     // Host access phase with the bus available
    logic rom_region;
    logic host_done;

    // Grant only between host access phases, hold while requested
    always_ff @(posedge clk) begin
        if (rst) begin
            granted <= 1'b0;
        end else if (mcu_busrq_n) begin
            granted <= 1'b0;
        end else if (!(psel && penable)) begin
            granted <= 1'b1;
        end
    end

    assign mcu_busak_n = ~granted;

    assign host_acc   = psel & penable & ~granted;
    assign rom_region = (bus.region == rom) || (bus.region == rom_bank);
    assign host_done  = host_acc & (~rom_region | rom_ok);  // ROM waits for data

    // Bus source select
    assign bus.addr = granted ? mcu_addr : paddr;
    assign bus.dout = granted ? mcu_dout : pwdata;
    assign bus.we   = granted ? mcu_we   : host_done & pwrite;
    assign bus.rd   = granted ? mcu_rd   : host_done & ~pwrite;

    always_comb begin
        rom_cs = 1'b0;
        if (rom_region) begin
            rom_cs = granted ? mcu_rd : host_acc;
        end
    end

    assign pready = host_done;
    assign prdata = bus.din;

endmodule

// ==== common/main_bus_if.sv ====
// Shared main bus between host, MCU, decoder and control registers
// Modports for the bus master, the address decoder and snooping registers

`timescale 1ns/10ps
`include "flstory_cfg.svh"

interface main_bus_if import flstory_pkg::*; ();

    logic [`FL_AW-1:0] addr;
    logic [7:0]        dout;     // Master write data
    logic [7:0]        din;      // Read data back to the master
    logic              we;
    logic              rd;
    region_t           region;

    modport master (
        output addr, dout, we, rd,
        input  din, region
    );

    modport decoder (
        input  addr, dout, we, rd,
        output din, region
    );

    // Registers only watch the bus
    modport snoop (
        input addr, dout, din, we, rd, region
    );

endinterface

// ==== common/flstory_pkg.sv ====
// Shared types of the main CPU bus block
// Decoded region enum, ROM bank layout enum, video configuration struct

package flstory_pkg;

    // Target of the current main bus cycle
    typedef enum logic [3:0] {
        rom,
        rom_bank,
        vram,
        mcu_latch,
        sub_ctl,     // D001 sub halt
        ctl,         // D002 sub reset and bank
        snd,
        cab,
        oram,
        pal_lo,
        pal_hi,
        vcfg,
        sha,
        none
    } region_t;

    // ROM bank layout of the board variant
    typedef enum logic [1:0] {
        no_banks,
        two_banks,
        four_banks
    } bank_mode_t;

    // Video configuration as seen by the video block
    typedef struct packed {
        logic [1:0] pal_bank;
        logic [1:0] scr_bank;
        logic       scr_flen;
        logic       vflip;
        logic       hflip;
    } vid_cfg_t;

endpackage

// ==== common/flstory_cfg.svh ====
// Main CPU bus configuration macros
// Address widths, ROM bank layout and control register reset values

`ifndef FLSTORY_CFG_SVH
`define FLSTORY_CFG_SVH

// Main bus and memory widths
`define FL_AW        16
`define FL_ROM_AW    17   // Bit 16 picks the banked half
`define FL_PAL_AW    10

// ROM bank layout, a bank_mode_t value
`define FL_BANK_MODE four_banks

// Control register values after reset
`define FL_BANK_RST      2'd0
`define FL_SUB_RSTN_RST  1'b0   // Sub CPU held in reset
`define FL_SUB_BUSRQ_RST 1'b0   // Sub CPU halted

`endif
